/* design/track_buffer_consts.svh */
// Track buffer geometry and tag reset values
`ifndef TRACK_BUFFER_CONSTS_SVH
`define TRACK_BUFFER_CONSTS_SVH

// ==================================================
// Track geometry
// ==================================================
`define SECTORS_PER_TRACK 17   // Sectors held in one track
`define SECTOR_BYTES 512       // Bytes per sector
`define TRACK_BYTES 8704       // 17 x 512, whole buffer

// ==================================================
// Tag values after reset
// ==================================================
// No real drive has these, so the first request always misses
`define NO_CYLINDER 16'hffff
`define NO_HEAD 4'hf

`endif

/* design/disk_geom_pkg.sv */
// Disk geometry package with widths for sectors, tracks and buffer addresses
`default_nettype none

`include "track_buffer_consts.svh"

package disk_geom_pkg;

    // Payload
    typedef logic [7:0] byte_t;               // One data byte

    // Drive side addressing
    typedef logic [15:0] cylinder_t;
    typedef logic [3:0]  head_t;
    typedef logic [7:0]  sector_num_t;        // One-based, as the drive counts

    // Buffer side addressing
    typedef logic [4:0]  sector_idx_t;        // Zero-based slot, 0..16
    typedef logic [8:0]  byte_off_t;          // Offset inside a sector
    typedef logic [13:0] buf_addr_t;          // {slot, offset}

    // One bit per cached sector
    typedef logic [`SECTORS_PER_TRACK-1:0] sector_mask_t;

endpackage

`default_nettype wire

/* design/buffer_ctrl_pkg.sv */
// Buffer control package with sequencer states and buffer occupancy
`default_nettype none

package buffer_ctrl_pkg;

    // Sequencer FSM
    typedef enum logic [3:0] {
        st_idle, st_check,
        st_flush_start, st_flush_wait,   // Write-back of dirty sectors
        st_fill_start, st_fill_wait,     // Single sector read from disk
        st_host_read, st_host_write,     // 512 byte host transfer
        st_done, st_error
    } seq_state_t;

    // What the buffer holds
    typedef enum logic [1:0] {
        occ_empty,   // Nothing cached
        occ_clean,   // Cached, matches disk
        occ_dirty    // At least one sector waits for write-back
    } occupancy_t;

endpackage

`default_nettype wire

/* design/sector_ram.sv */
// Sector RAM holding one track, synchronous write and asynchronous read
`timescale 1ns/1ps
`default_nettype none

`include "track_buffer_consts.svh"

module sector_ram (
    input  logic                  clk,
    input  disk_geom_pkg::buf_addr_t addr,
    input  disk_geom_pkg::byte_t     wdata,
    input  logic                  write,
    output disk_geom_pkg::byte_t     rdata
);
    import disk_geom_pkg::*;

    byte_t mem [0:`TRACK_BYTES-1];   // 17 sectors back to back

    always_ff @(posedge clk) begin
        if (write) begin
            mem[addr] <= wdata;
        end
    end

    assign rdata = mem[addr];   // Zero-cycle read for host and disk

    // Slot 17 and up do not exist
    a_addr_in_range: assert property (@(posedge clk) write |-> (addr < `TRACK_BYTES));

endmodule

`default_nettype wire

/* design/cache_tags.sv */
// Cache tags for the cached track, with valid and dirty bitmaps and hit detection
`timescale 1ns/1ps
`default_nettype none

`include "track_buffer_consts.svh"

module cache_tags (
    input  logic                      clk,
    input  logic                      reset_n,
    input  disk_geom_pkg::cylinder_t  req_cylinder,
    input  disk_geom_pkg::head_t      req_head,
    input  disk_geom_pkg::sector_idx_t slot,
    input  logic                      retag,
    input  logic                      mark_valid,
    input  logic                      mark_dirty,
    input  logic                      clear_dirty,
    output logic                      track_hit,
    output logic                      slot_valid,
    output logic                      any_dirty,
    output disk_geom_pkg::sector_idx_t first_dirty,
    output disk_geom_pkg::cylinder_t  cached_cylinder,
    output disk_geom_pkg::head_t      cached_head
);
    import disk_geom_pkg::*;
    import buffer_ctrl_pkg::*;

    sector_mask_t valid_mask;
    sector_mask_t dirty_mask;
    sector_mask_t slot_bit;      // One-hot of the commanded slot
    occupancy_t   occupancy;

    assign slot_bit = sector_mask_t'(1) << slot;

    // ==================================================
    // Tag and bitmap registers
    // ==================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cached_cylinder <= `NO_CYLINDER;
            cached_head     <= `NO_HEAD;
            valid_mask      <= '0;
            dirty_mask      <= '0;
            occupancy       <= occ_empty;
        end else if (retag) begin
            // New track, nothing in it yet
            cached_cylinder <= req_cylinder;
            cached_head     <= req_head;
            valid_mask      <= '0;
            dirty_mask      <= '0;
            occupancy       <= occ_clean;
        end else begin
            if (mark_valid || mark_dirty) begin
                valid_mask <= valid_mask | slot_bit;
            end
            if (mark_dirty) begin
                dirty_mask <= dirty_mask | slot_bit;
                occupancy  <= occ_dirty;
            end else if (clear_dirty) begin
                dirty_mask <= dirty_mask & ~slot_bit;
                if ((dirty_mask & ~slot_bit) == '0) begin
                    occupancy <= occ_clean;   // Last one written back
                end
            end
        end
    end

    // ==================================================
    // Lookup
    // ==================================================
    assign track_hit = (occupancy != occ_empty) &&
                       (cached_cylinder == req_cylinder) &&
                       (cached_head == req_head);
    assign slot_valid = |(valid_mask & slot_bit);
    assign any_dirty  = |dirty_mask;

    // Lowest dirty slot wins, so write-back runs in ascending order
    always_comb begin
        first_dirty = '0;
        for (int i = `SECTORS_PER_TRACK - 1; i >= 0; i--) begin
            if (dirty_mask[i]) first_dirty = sector_idx_t'(i);
        end
    end

    a_dirty_implies_valid: assert property (
        @(posedge clk) disable iff (!reset_n) (dirty_mask & ~valid_mask) == '0);

endmodule

`default_nettype wire

/* design/buffer_sequencer.sv */
// Buffer sequencer FSM for request check, write-back, fill and host transfer
`timescale 1ns/1ps
`default_nettype none

`include "track_buffer_consts.svh"

module buffer_sequencer (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       req_read,
    input  logic                       req_write,
    input  disk_geom_pkg::sector_num_t req_sector,
    input  disk_geom_pkg::head_t       req_head,
    input  disk_geom_pkg::cylinder_t   req_cylinder,
    input  logic                       host_read,
    input  logic                       host_write,
    input  disk_geom_pkg::byte_t       host_wdata,
    input  logic                       disk_ready,
    input  logic                       disk_error,
    input  disk_geom_pkg::byte_t       disk_rdata,
    input  logic                       disk_byte_valid,
    input  logic                       track_hit,
    input  logic                       slot_valid,
    input  logic                       any_dirty,
    input  disk_geom_pkg::sector_idx_t first_dirty,
    input  disk_geom_pkg::cylinder_t   cached_cylinder,
    input  disk_geom_pkg::head_t       cached_head,
    output logic                       buf_ready,
    output logic                       buf_error,
    output logic                       host_drq,
    output logic                       disk_read_start,
    output logic                       disk_write_start,
    output logic                       disk_byte_ack,
    output disk_geom_pkg::sector_num_t disk_sector,
    output disk_geom_pkg::head_t       disk_head,
    output disk_geom_pkg::cylinder_t   disk_cylinder,
    output disk_geom_pkg::buf_addr_t   ram_addr,
    output logic                       ram_write,
    output disk_geom_pkg::byte_t       ram_wdata,
    output disk_geom_pkg::sector_idx_t slot,
    output logic                       retag,
    output logic                       mark_valid,
    output logic                       mark_dirty,
    output logic                       clear_dirty
);
    import disk_geom_pkg::*;
    import buffer_ctrl_pkg::*;

    seq_state_t  state;
    byte_off_t   offset;       // Byte inside the current sector
    sector_idx_t op_slot;      // Slot the host asked for
    sector_idx_t wb_slot;      // Slot being written back
    logic        op_write;     // Request is a host write
    logic        accept;
    logic        last_byte;
    logic        fill_byte;    // Disk byte arrives during fill

    assign accept    = (state == st_idle) && (req_read || req_write);
    assign last_byte = (offset == byte_off_t'(`SECTOR_BYTES - 1));
    assign fill_byte = (state == st_fill_wait) && disk_byte_valid && !disk_error;

    // ==================================================
    // RAM and tag commands
    // ==================================================
    assign slot      = (state == st_flush_wait) ? wb_slot : op_slot;
    assign ram_addr  = {slot, offset};            // slot * 512 + offset
    assign ram_write = fill_byte || ((state == st_host_write) && host_write);
    assign ram_wdata = (state == st_fill_wait) ? disk_rdata : host_wdata;
    assign host_drq  = (state == st_host_read) || (state == st_host_write);

    assign retag       = (state == st_check) && !track_hit && !any_dirty;
    assign mark_valid  = (state == st_fill_wait) && disk_ready && !disk_error && !disk_byte_valid;
    assign mark_dirty  = (state == st_host_write) && host_write && last_byte;
    assign clear_dirty = (state == st_flush_wait) && disk_ready && !disk_error;

    // ==================================================
    // Control FSM
    // ==================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state            <= st_idle;
            offset           <= '0;
            buf_ready        <= 1'b0;
            buf_error        <= 1'b0;
            disk_read_start  <= 1'b0;
            disk_write_start <= 1'b0;
            disk_byte_ack    <= 1'b0;
        end else begin
            // Pulses last one cycle
            buf_ready        <= 1'b0;
            buf_error        <= 1'b0;
            disk_read_start  <= 1'b0;
            disk_write_start <= 1'b0;
            disk_byte_ack    <= 1'b0;
            case (state)
                st_idle: begin
                    offset <= '0;
                    if (accept) state <= st_check;
                end
                st_check: begin
                    offset <= '0;
                    if (track_hit) begin
                        if (op_write)        state <= st_host_write;   // Whole sector, no fill
                        else if (slot_valid) state <= st_host_read;
                        else                 state <= st_fill_start;
                    end else if (any_dirty) begin
                        state <= st_flush_start;   // Old track goes out first
                    end else begin
                        state <= op_write ? st_host_write : st_fill_start;
                    end
                end
                st_flush_start: begin
                    disk_write_start <= 1'b1;
                    state            <= st_flush_wait;
                end
                st_flush_wait: begin
                    if (disk_error) begin
                        buf_error <= 1'b1;
                        state     <= st_error;
                    end else if (disk_ready) begin
                        state <= st_check;   // Look for the next dirty slot
                    end else if (disk_byte_valid) begin
                        offset <= offset + 1'b1;   // Drive took the byte
                    end
                end
                st_fill_start: begin
                    disk_read_start <= 1'b1;
                    state           <= st_fill_wait;
                end
                st_fill_wait: begin
                    if (disk_error) begin
                        buf_error <= 1'b1;
                        state     <= st_error;
                    end else if (disk_byte_valid) begin
                        offset        <= offset + 1'b1;
                        disk_byte_ack <= 1'b1;
                    end else if (disk_ready) begin
                        offset <= '0;
                        state  <= st_host_read;
                    end
                end
                st_host_read, st_host_write: begin
                    if ((state == st_host_read) ? host_read : host_write) begin
                        offset <= offset + 1'b1;
                        if (last_byte) state <= st_done;
                    end
                end
                st_done: begin
                    buf_ready <= 1'b1;
                    state     <= st_idle;
                end
                st_error: state <= st_idle;   // buf_error is already out
                default:  state <= st_idle;
            endcase
        end
    end

    // Request and disk address registers
    always_ff @(posedge clk) begin
        if (accept) begin
            op_write <= !req_read;   // Read wins over write
            op_slot  <= sector_idx_t'(req_sector - 8'd1);
        end
        if (state == st_flush_start) begin
            wb_slot       <= first_dirty;
            disk_sector   <= sector_num_t'(first_dirty) + 8'd1;
            disk_head     <= cached_head;       // Old track
            disk_cylinder <= cached_cylinder;
        end else if (state == st_fill_start) begin
            disk_sector   <= sector_num_t'(op_slot) + 8'd1;
            disk_head     <= req_head;
            disk_cylinder <= req_cylinder;
        end
    end

    a_no_drq_with_start: assert property (@(posedge clk) disable iff (!reset_n)
        !(host_drq && (disk_read_start || disk_write_start)));

endmodule

`default_nettype wire

/* design/track_buffer.sv */
// Track buffer top with sector RAM, cache tags and sequencer
`timescale 1ns/1ps
`default_nettype none

module track_buffer (
    input  logic                       clk,
    input  logic                       reset_n,
    // Request
    input  logic                       req_read,
    input  logic                       req_write,
    input  disk_geom_pkg::sector_num_t req_sector,
    input  disk_geom_pkg::head_t       req_head,
    input  disk_geom_pkg::cylinder_t   req_cylinder,
    output logic                       buf_ready,
    output logic                       buf_error,
    // Host data port
    input  logic                       host_read,
    input  logic                       host_write,
    input  disk_geom_pkg::byte_t       host_wdata,
    output disk_geom_pkg::byte_t       host_rdata,
    output logic                       host_drq,
    // Drive
    input  logic                       disk_ready,
    input  logic                       disk_error,
    input  disk_geom_pkg::byte_t       disk_rdata,
    input  logic                       disk_byte_valid,
    output logic                       disk_read_start,
    output logic                       disk_write_start,
    output disk_geom_pkg::sector_num_t disk_sector,
    output disk_geom_pkg::head_t       disk_head,
    output disk_geom_pkg::cylinder_t   disk_cylinder,
    output disk_geom_pkg::byte_t       disk_wdata,
    output logic                       disk_byte_ack
);
    import disk_geom_pkg::*;

    buf_addr_t   ram_addr;
    byte_t       ram_wdata;
    byte_t       ram_rdata;
    logic        ram_write;
    sector_idx_t slot;
    sector_idx_t first_dirty;
    cylinder_t   cached_cylinder;
    head_t       cached_head;
    logic        track_hit, slot_valid, any_dirty;
    logic        retag, mark_valid, mark_dirty, clear_dirty;

    assign host_rdata = ram_rdata;   // Same port feeds host and drive
    assign disk_wdata = ram_rdata;

    sector_ram u_ram (.clk, .addr(ram_addr), .wdata(ram_wdata), .write(ram_write),
                      .rdata(ram_rdata));

    cache_tags u_tags (.clk, .reset_n, .req_cylinder, .req_head, .slot, .retag,
                       .mark_valid, .mark_dirty, .clear_dirty, .track_hit, .slot_valid,
                       .any_dirty, .first_dirty, .cached_cylinder, .cached_head);

    buffer_sequencer u_seq (.clk, .reset_n, .req_read, .req_write, .req_sector, .req_head,
                            .req_cylinder, .host_read, .host_write, .host_wdata, .disk_ready,
                            .disk_error, .disk_rdata, .disk_byte_valid, .track_hit, .slot_valid,
                            .any_dirty, .first_dirty, .cached_cylinder, .cached_head, .buf_ready,
                            .buf_error, .host_drq, .disk_read_start, .disk_write_start,
                            .disk_byte_ack, .disk_sector, .disk_head, .disk_cylinder, .ram_addr,
                            .ram_write, .ram_wdata, .slot, .retag, .mark_valid, .mark_dirty,
                            .clear_dirty);

endmodule

`default_nettype wire

/* tb/tb_clock_gen.sv */
// Testbench clock and reset source, 4 ns clock with reset held for 4 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset_n
);
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 250 MHz
    end

    initial begin
        reset_n = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;          // Released on a falling edge like every input
    end

endmodule

`default_nettype wire

/* tb/track_buffer_tb.sv */
// Track buffer testbench with random requests, a disk model and a reference model
`timescale 1ns/1ps
`default_nettype none

`include "track_buffer_consts.svh"

module track_buffer_tb;
    import disk_geom_pkg::*;

    localparam int NUM_REQUESTS    = 60;
    localparam int IMAGE_BYTES     = 3 * 2 * `SECTORS_PER_TRACK * `SECTOR_BYTES;
    localparam int WATCHDOG_CYCLES = NUM_REQUESTS * 2 * `SECTORS_PER_TRACK * 600;

    logic clk, reset_n;
    logic req_read, req_write, buf_ready, buf_error;
    sector_num_t req_sector, disk_sector;
    head_t       req_head, disk_head;
    cylinder_t   req_cylinder, disk_cylinder;
    logic        host_read, host_write, host_drq;
    byte_t       host_wdata, host_rdata, disk_rdata, disk_wdata;
    logic        disk_ready, disk_error, disk_byte_valid, disk_byte_ack;
    logic        disk_read_start, disk_write_start;

    // ==================================================
    // Shared state
    // ==================================================
    logic [31:0]  req_lfsr  = 32'hdd834c84;   // Request and host stream
    logic [31:0]  disk_lfsr = 32'hdd834c84;   // Drive stream
    byte_t        image [0:IMAGE_BYTES-1];    // Whole disk of 3 cylinders and 2 heads
    byte_t        m_buf [0:`TRACK_BYTES-1];   // Expected buffer contents
    cylinder_t    m_cyl;
    head_t        m_head;
    logic         m_occ;
    sector_mask_t m_valid, m_dirty;
    logic [28:0]  ev_q [$];                   // {write, cyl, head, sector} per start
    logic         inject_error, error_done;
    int           checks, errors, ready_pulses, error_pulses, ack_pulses, fill_bytes;
    int           cur_cyl, cur_head, cur_sec;

    tb_clock_gen u_clk (.clk, .reset_n);

    track_buffer uut (.*);

    // ==================================================
    // Helpers
    // ==================================================
    function logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);   // Taps 32,22,2,1
    endfunction

    function logic [15:0] req_bits(input int n);
        req_bits = '0;
        for (int i = 0; i < n; i++) begin
            req_bits = {req_bits[14:0], req_lfsr[0]};
            req_lfsr = lfsr_step(req_lfsr);
        end
    endfunction

    function logic [15:0] disk_bits(input int n);
        disk_bits = '0;
        for (int i = 0; i < n; i++) begin
            disk_bits = {disk_bits[14:0], disk_lfsr[0]};
            disk_lfsr = lfsr_step(disk_lfsr);
        end
    endfunction

    function int image_index(input int cyl, input int head, input int sec);
        image_index = ((cyl * 2 + head) * `SECTORS_PER_TRACK + sec - 1) * `SECTOR_BYTES;
    endfunction

    task automatic expect_equal(input logic [31:0] got, input logic [31:0] exp,
                                input string what);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Pulse counters sampled at the falling edge
    always @(negedge clk) begin
        if (reset_n) begin
            ready_pulses += buf_ready;
            error_pulses += buf_error;
            ack_pulses   += disk_byte_ack;
        end
    end

    // ==================================================
    // Disk model
    // ==================================================
    initial begin : disk_model
        logic is_wr;
        logic abort;
        int   base;
        disk_ready = 1'b0;
        disk_error = 1'b0;
        disk_rdata = '0;
        disk_byte_valid = 1'b0;
        for (int i = 0; i < IMAGE_BYTES; i++) begin
            image[i] = byte_t'(i) ^ byte_t'(i >> 8) ^ 8'h3c;   // Known pattern
        end
        forever begin
            @(negedge clk);
            if (disk_read_start || disk_write_start) begin
                is_wr = disk_write_start;
                abort = 1'b0;
                ev_q.push_back({is_wr, disk_cylinder, disk_head, disk_sector});
                base = image_index(disk_cylinder, disk_head, disk_sector);
                repeat (disk_bits(3)) @(negedge clk);   // Seek time
                for (int b = 0; b < `SECTOR_BYTES && !abort; b++) begin
                    while (disk_bits(2) == 0) begin
                        disk_byte_valid = 1'b0;
                        @(negedge clk);
                    end
                    if (inject_error && !is_wr && b == 100) begin
                        disk_byte_valid = 1'b0;
                        disk_error      = 1'b1;   // Bad sector mid-read
                        inject_error    = 1'b0;
                        abort           = 1'b1;
                    end else if (is_wr) begin
                        image[base + b] = disk_wdata;   // Byte at current offset
                        disk_byte_valid = 1'b1;
                    end else begin
                        disk_rdata      = image[base + b];
                        disk_byte_valid = 1'b1;
                        fill_bytes++;
                    end
                    @(negedge clk);
                end
                disk_byte_valid = 1'b0;
                disk_error      = 1'b0;
                disk_ready      = !abort;
                @(negedge clk);
                disk_ready = 1'b0;
            end
        end
    end

    // ==================================================
    // One request against the reference model
    // ==================================================
    task automatic run_request(input int n);
        logic         rd, hit, need_fill, will_err;
        int           slot, bad;
        sector_mask_t flush_mask;
        logic [28:0]  exp_ev [$];
        byte_t        exp_byte;
        rd = req_bits(1);
        if (req_bits(2) == 0) begin   // Mostly stay on the same track
            cur_cyl  = req_bits(2) % 3;
            cur_head = req_bits(1);
        end
        if (req_bits(1)) cur_sec = req_bits(5) % `SECTORS_PER_TRACK + 1;
        slot       = cur_sec - 1;
        hit        = m_occ && cur_cyl == m_cyl && cur_head == m_head;
        flush_mask = hit ? '0 : m_dirty;
        need_fill  = rd && !(hit && m_valid[slot]);
        will_err   = need_fill && !error_done && n >= 20;
        error_done   |= will_err;
        inject_error = will_err;
        for (int s = 0; s < `SECTORS_PER_TRACK; s++) begin
            if (flush_mask[s]) exp_ev.push_back({1'b1, m_cyl, m_head, sector_num_t'(s + 1)});
        end
        if (need_fill) exp_ev.push_back({1'b0, cylinder_t'(cur_cyl), head_t'(cur_head),
                                         sector_num_t'(cur_sec)});

        req_read     = rd;
        req_write    = !rd;
        req_sector   = cur_sec;
        req_head     = cur_head;   // Held until completion
        req_cylinder = cur_cyl;
        @(negedge clk);
        req_read  = 1'b0;
        req_write = 1'b0;
        while (!host_drq && !buf_error) @(negedge clk);
        expect_equal(buf_error, will_err, "buf_error");

        // Write-back and disk starts are all done by now
        for (int s = 0; s < `SECTORS_PER_TRACK; s++) begin
            if (flush_mask[s]) begin
                bad = 0;
                for (int b = 0; b < `SECTOR_BYTES; b++) begin
                    if (image[image_index(m_cyl, m_head, s + 1) + b] !== m_buf[s * 512 + b])
                        bad++;
                end
                expect_equal(bad, 0, "written-back byte mismatches");
            end
        end
        expect_equal(ev_q.size(), exp_ev.size(), "disk start count");
        foreach (exp_ev[i]) begin
            if (i < ev_q.size()) expect_equal(ev_q[i], exp_ev[i], "disk start {wr,cyl,head,sec}");
        end
        ev_q.delete();
        if (!hit) begin   // Tags move to the new track
            m_occ   = 1'b1;
            m_cyl   = cur_cyl;
            m_head  = cur_head;
            m_valid = '0;
            m_dirty = '0;
        end

        if (buf_error) begin
            expect_equal(host_drq, 1'b0, "host_drq with buf_error");
            @(negedge clk);   // Error state back to idle
        end else begin
            for (int b = 0; b < `SECTOR_BYTES; b++) begin
                while (req_bits(2) == 0) begin   // Host pause
                    host_read  = 1'b0;
                    host_write = 1'b0;
                    @(negedge clk);
                end
                expect_equal(host_drq, 1'b1, "host_drq during transfer");
                if (rd) begin
                    exp_byte = need_fill ? image[image_index(cur_cyl, cur_head, cur_sec) + b]
                                         : m_buf[slot * 512 + b];
                    expect_equal(host_rdata, exp_byte, "host read byte");
                    m_buf[slot * 512 + b] = exp_byte;
                    host_read = 1'b1;
                end else begin
                    host_wdata = req_bits(8);
                    m_buf[slot * 512 + b] = host_wdata;
                    host_write = 1'b1;
                end
                @(negedge clk);
            end
            host_read  = 1'b0;
            host_write = 1'b0;
            expect_equal(host_drq, 1'b0, "host_drq after last byte");
            while (!buf_ready) @(negedge clk);
            m_valid[slot] = 1'b1;
            if (!rd) m_dirty[slot] = 1'b1;
        end
    endtask

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin : stimulus
        req_read = 1'b0;
        req_write = 1'b0;
        req_sector = 8'd1;
        req_head = '0;
        req_cylinder = '0;
        host_read = 1'b0;
        host_write = 1'b0;
        host_wdata = '0;
        {m_occ, m_valid, m_dirty, m_cyl, m_head} = '0;
        {inject_error, error_done} = '0;
        {cur_cyl, cur_head, cur_sec} = {32'd0, 32'd0, 32'd1};
        @(posedge reset_n);
        @(negedge clk);
        expect_equal({buf_ready, buf_error, host_drq, disk_read_start, disk_write_start,
                      disk_byte_ack}, '0, "control outputs after reset");
        for (int n = 0; n < NUM_REQUESTS; n++) run_request(n);
        repeat (8) @(negedge clk);
        expect_equal(ready_pulses + error_pulses, NUM_REQUESTS, "completion pulses");
        expect_equal(error_pulses, 1, "buf_error pulses");
        expect_equal(ack_pulses, fill_bytes, "disk_byte_ack pulses");
        $display("Requests: %0d, checks: %0d, errors: %0d", NUM_REQUESTS, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+design
design/disk_geom_pkg.sv
design/buffer_ctrl_pkg.sv
design/sector_ram.sv
design/cache_tags.sv
design/buffer_sequencer.sv
design/track_buffer.sv
tb/tb_clock_gen.sv
tb/track_buffer_tb.sv

/* Bender.yml */
package:
  name: track_buffer

sources:
  - include_dirs:
      - design
    files:
      - design/disk_geom_pkg.sv
      - design/buffer_ctrl_pkg.sv
      - design/sector_ram.sv
      - design/cache_tags.sv
      - design/buffer_sequencer.sv
      - design/track_buffer.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - tb/tb_clock_gen.sv
      - tb/track_buffer_tb.sv
